// ==== Makefile ====
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module core_tb

sim:
	verilator --binary --timing --assert -f sim.f --top-module core_tb -o core_tb_sim
	./obj_dir/core_tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// ==== hdl/alu.sv ====
/*
 * Integer ALU for RV32I
 * Flags come from the shared adder and hold for subtraction
 */
`default_nettype none

module alu
  import rv_pkg::*;
(
  input  wire word_t   a,
  input  wire word_t   b,
  input  wire alu_op_t op,
  output word_t        result,
  output logic         zero,
  output logic         negative,
  output logic         carry_out,
  output logic         overflow
);

  logic        sub_mode;
  word_t       b_eff;
  logic [32:0] sum;

  // Compares run through the subtractor
  assign sub_mode = (op == ALU_SUB) || (op == ALU_SLT) || (op == ALU_SLTU);
  assign b_eff    = sub_mode ? ~b : b;
  assign sum      = {1'b0, a} + {1'b0, b_eff} + {32'b0, sub_mode};

  assign carry_out = sum[32];
  assign negative  = sum[31];
  assign zero      = (sum[31:0] == '0);
  assign overflow  = (a[31] == b_eff[31]) && (sum[31] != a[31]);

  always_comb begin
    case (op)
      ALU_ADD, ALU_SUB: result = sum[31:0];
      ALU_SLL:          result = a << b[4:0];
      ALU_SLT:          result = {31'b0, negative ^ overflow};
      ALU_SLTU:         result = {31'b0, ~carry_out};
      ALU_XOR:          result = a ^ b;
      ALU_SRL:          result = a >> b[4:0];
      ALU_SRA:          result = word_t'($signed(a) >>> b[4:0]);
      ALU_OR:           result = a | b;
      ALU_AND:          result = a & b;
      ALU_PASS_B:       result = b;
      default:          result = sum[31:0];
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/control_unit.sv ====
/*
 * Multicycle control FSM: fetch, decode, execute, memory, writeback
 * Decodes the instruction, resolves branches and runs the bus cycles
 */
`default_nettype none

module control_unit
  import rv_pkg::*;
(
  input  wire logic    clock,
  input  wire logic    rst,
  input  wire logic    mem_ack,
  input  wire status_t status,
  output ctrl_t        ctrl,
  output logic         mem_rd_en,
  output logic         mem_wr_en
);

  state_t  state;
  state_t  next_state;
  logic    started;
  logic    branch_taken;
  logic    take_branch;
  alu_op_t arith_op;
  alu_op_t op_alu;
  logic    a_pc;
  logic    b_imm;
  wb_sel_t wb_sel;
  logic    writes_rd;
  logic    is_jump;

  // Holds the first fetch back by one cycle out of reset
  always_ff @(posedge clock) begin
    if (rst) begin
      state        <= FETCH;
      started      <= 1'b0;
      branch_taken <= 1'b0;
    end else begin
      state   <= next_state;
      started <= 1'b1;
      if (state == DECODE) begin
        branch_taken <= take_branch;
      end
    end
  end

  // Flags of rs1 - rs2, driven during DECODE
  always_comb begin
    case (status.funct3)
      F3_BEQ:  take_branch = status.zero;
      F3_BNE:  take_branch = ~status.zero;
      F3_BLT:  take_branch = status.negative ^ status.overflow;
      F3_BGE:  take_branch = ~(status.negative ^ status.overflow);
      F3_BLTU: take_branch = ~status.carry_out;
      F3_BGEU: take_branch = status.carry_out;
      default: take_branch = 1'b0;
    endcase
  end

  always_comb begin
    case (status.funct3)
      3'b000:  arith_op = (status.opcode == OP_REG && status.funct7_5) ? ALU_SUB : ALU_ADD;
      3'b001:  arith_op = ALU_SLL;
      3'b010:  arith_op = ALU_SLT;
      3'b011:  arith_op = ALU_SLTU;
      3'b100:  arith_op = ALU_XOR;
      3'b101:  arith_op = status.funct7_5 ? ALU_SRA : ALU_SRL;
      3'b110:  arith_op = ALU_OR;
      default: arith_op = ALU_AND;
    endcase
  end

  always_comb begin
    op_alu    = ALU_ADD;
    a_pc      = 1'b0;
    b_imm     = 1'b1;
    wb_sel    = WB_ALU;
    writes_rd = 1'b1;
    is_jump   = 1'b0;
    case (status.opcode)
      OP_LUI:    op_alu = ALU_PASS_B;
      OP_AUIPC:  a_pc = 1'b1;
      OP_JAL: begin
        a_pc    = 1'b1;
        wb_sel  = WB_PC4;
        is_jump = 1'b1;
      end
      OP_JALR: begin
        wb_sel  = WB_PC4;
        is_jump = 1'b1;
      end
      OP_BRANCH: begin
        a_pc      = 1'b1;
        writes_rd = 1'b0;
      end
      OP_LOAD:   wb_sel = WB_MEM;
      OP_STORE:  writes_rd = 1'b0;
      OP_IMM:    op_alu = arith_op;
      OP_REG: begin
        op_alu = arith_op;
        b_imm  = 1'b0;
      end
      default:   writes_rd = 1'b0;
    endcase
  end

  always_comb begin
    ctrl            = '0;
    ctrl.alua_src   = a_pc;
    ctrl.alub_src   = b_imm;
    ctrl.alu_op     = op_alu;
    ctrl.wr_reg_src = wb_sel;
    mem_rd_en       = 1'b0;
    mem_wr_en       = 1'b0;
    next_state      = state;
    case (state)
      FETCH: begin
        mem_rd_en  = started;
        ctrl.ir_en = started & mem_ack;
        if (started && mem_ack) begin
          next_state = DECODE;
        end
      end
      DECODE: begin
        ctrl.alua_src = 1'b0;
        ctrl.alub_src = 1'b0;
        ctrl.alu_op   = ALU_SUB;
        next_state    = EXECUTE;
      end
      EXECUTE: begin
        case (status.opcode)
          OP_BRANCH: begin
            ctrl.pc_en  = 1'b1;
            ctrl.pc_src = branch_taken;
            next_state  = FETCH;
          end
          OP_JAL, OP_JALR: begin
            ctrl.pc_en  = 1'b1;
            ctrl.pc_src = 1'b1;
            next_state  = WRITEBACK;
          end
          OP_LOAD, OP_STORE: next_state = MEMORY;
          default:           next_state = WRITEBACK;
        endcase
      end
      MEMORY: begin
        ctrl.mem_addr_src = 1'b1;
        mem_rd_en         = (status.opcode == OP_LOAD);
        mem_wr_en         = (status.opcode == OP_STORE);
        if (mem_ack) begin
          next_state = WRITEBACK;
        end
      end
      WRITEBACK: begin
        ctrl.wr_reg_en = writes_rd;
        ctrl.pc_en     = ~is_jump;
        next_state     = FETCH;
      end
      default: next_state = FETCH;
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/core.sv ====
/*
 * Multicycle RV32I core top
 * Joins dataflow and control unit on a Wishbone-style bus
 */
`default_nettype none

module core
  import rv_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  rst,
  input  wire word_t bus_rd_data,
  input  wire logic  bus_ack,
  output word_t      bus_wr_data,
  output word_t      bus_addr,
  output logic       bus_cyc,
  output logic       bus_stb,
  output logic       bus_we,
  output logic [3:0] bus_sel
);

  ctrl_t   ctrl;
  status_t status;
  logic    mem_rd_en;
  logic    mem_wr_en;

  dataflow df (
    .clock    (clock),
    .rst      (rst),
    .ctrl     (ctrl),
    .rd_data  (bus_rd_data),
    .status   (status),
    .wr_data  (bus_wr_data),
    .mem_addr (bus_addr)
  );

  control_unit uc (
    .clock     (clock),
    .rst       (rst),
    .mem_ack   (bus_ack),
    .status    (status),
    .ctrl      (ctrl),
    .mem_rd_en (mem_rd_en),
    .mem_wr_en (mem_wr_en)
  );

  // Word accesses only
  assign bus_cyc = mem_rd_en | mem_wr_en;
  assign bus_stb = bus_cyc;
  assign bus_we  = mem_wr_en;
  assign bus_sel = 4'b1111;

endmodule

`default_nettype wire

// ==== hdl/dataflow.sv ====
/*
 * Datapath of the multicycle core: PC, instruction and load data registers,
 * immediate generation, ALU operand and writeback selection, bus address
 */
`default_nettype none

module dataflow
  import rv_pkg::*;
(
  input  wire logic  clock,
  input  wire logic  rst,
  input  wire ctrl_t ctrl,
  input  wire word_t rd_data,
  output status_t    status,
  output word_t      wr_data,
  output word_t      mem_addr
);

  word_t pc;
  word_t pc_old;
  word_t ir;
  word_t mdr;
  word_t imm;
  word_t pc_plus4;
  word_t next_pc;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t rs1_data;
  word_t rs2_data;
  word_t wb_data;
  logic  zero;
  logic  negative;
  logic  carry_out;
  logic  overflow;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= RESET_PC;
    end else if (ctrl.pc_en) begin
      pc <= next_pc;
    end
  end

  // pc_old keeps the address of the instruction in flight
  always_ff @(posedge clock) begin
    if (ctrl.ir_en) begin
      ir     <= rd_data;
      pc_old <= pc;
    end
    mdr <= rd_data;
  end

  always_comb begin
    case (opcode_t'(ir[6:0]))
      OP_STORE:        imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
      OP_BRANCH:       imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
      OP_LUI, OP_AUIPC: imm = {ir[31:12], 12'b0};
      OP_JAL:          imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
      default:         imm = {{20{ir[31]}}, ir[31:20]};
    endcase
  end

  register_file regs (
    .clock    (clock),
    .rst      (rst),
    .rs1      (reg_addr_t'(ir[19:15])),
    .rs2      (reg_addr_t'(ir[24:20])),
    .rd       (reg_addr_t'(ir[11:7])),
    .wr_en    (ctrl.wr_reg_en),
    .wr_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign alu_a = ctrl.alua_src ? pc_old : rs1_data;
  assign alu_b = ctrl.alub_src ? imm : rs2_data;

  alu alu_inst (
    .a         (alu_a),
    .b         (alu_b),
    .op        (ctrl.alu_op),
    .result    (alu_result),
    .zero      (zero),
    .negative  (negative),
    .carry_out (carry_out),
    .overflow  (overflow)
  );

  assign pc_plus4 = pc_old + 32'd4;
  // JALR target has bit 0 cleared
  assign next_pc  = ctrl.pc_src ? {alu_result[31:1], 1'b0} : pc_plus4;

  always_comb begin
    case (ctrl.wr_reg_src)
      WB_MEM:  wb_data = mdr;
      WB_PC4:  wb_data = pc_plus4;
      default: wb_data = alu_result;
    endcase
  end

  assign mem_addr = ctrl.mem_addr_src ? alu_result : pc;
  assign wr_data  = rs2_data;

  assign status = '{
    opcode:    opcode_t'(ir[6:0]),
    funct3:    funct3_t'(ir[14:12]),
    funct7_5:  ir[30],
    zero:      zero,
    negative:  negative,
    carry_out: carry_out,
    overflow:  overflow
  };

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
/*
 * 32 x 32-bit register file, x0 reads as zero
 * Two combinational read ports, one clocked write port
 */
`default_nettype none

module register_file
  import rv_pkg::*;
(
  input  wire logic      clock,
  input  wire logic      rst,
  input  wire reg_addr_t rs1,
  input  wire reg_addr_t rs2,
  input  wire reg_addr_t rd,
  input  wire logic      wr_en,
  input  wire word_t     wr_data,
  output word_t          rs1_data,
  output word_t          rs2_data
);

  word_t regs [1:31];

  always_ff @(posedge clock) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && rd != '0) begin
      regs[rd] <= wr_data;
    end
  end

  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

// ==== hdl/rv_pkg.sv ====
/*
 * Shared types for the multicycle RV32I core: word and register index types,
 * opcode and ALU encodings, the control and status structs and the FSM states
 */
`default_nettype none

package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  localparam word_t RESET_PC = 32'h0000_0000;

  // Major opcodes
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_REG    = 7'b0110011;

  // Branch conditions in funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4} wb_sel_t;

  typedef struct packed {
    logic    alua_src;      // 0 rs1, 1 PC of the instruction
    logic    alub_src;      // 0 rs2, 1 immediate
    alu_op_t alu_op;
    logic    pc_en;
    logic    pc_src;        // 0 PC plus 4, 1 ALU result
    logic    ir_en;
    logic    mem_addr_src;  // 0 PC, 1 ALU result
    logic    wr_reg_en;
    wb_sel_t wr_reg_src;
  } ctrl_t;

  typedef struct packed {
    opcode_t opcode;
    funct3_t funct3;
    logic    funct7_5;
    logic    zero;
    logic    negative;
    logic    carry_out;
    logic    overflow;
  } status_t;

  typedef enum logic [2:0] {FETCH, DECODE, EXECUTE, MEMORY, WRITEBACK} state_t;

endpackage

`default_nettype wire

// ==== sim.f ====
hdl/rv_pkg.sv
hdl/alu.sv
hdl/register_file.sv
hdl/dataflow.sv
hdl/control_unit.sv
hdl/core.sv
test/clock_gen.sv
test/core_tb.sv

// ==== test/clock_gen.sv ====
/*
 * Testbench clock and reset source
 * 40 ns clock, reset held high for the first 3 cycles
 */
`default_nettype none

module clock_gen (
  output logic clock,
  output logic rst
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clock = 1'b0;
    forever #20 clock = ~clock;
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clock);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

// ==== test/core_tb.sv ====
/*
 * Testbench for the multicycle RV32I core: bus memory with random ack delay,
 * instruction-level reference model and per-transfer comparison
 */
`default_nettype none

module core_tb
  import rv_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  // About 80 executed instructions, at most 13 cycles each, doubled for margin
  localparam int MAX_CYCLES = 80 * 13 * 2;

  logic       clock;
  logic       rst;
  word_t      bus_rd_data;
  logic       bus_ack;
  word_t      bus_wr_data;
  word_t      bus_addr;
  logic       bus_cyc;
  logic       bus_stb;
  logic       bus_we;
  logic [3:0] bus_sel;

  word_t mem [0:255];
  word_t ref_mem [0:255];
  word_t ref_regs [0:31];
  word_t ref_pc;
  logic [31:0] rng_state = 32'h1630_c7fd;
  int    prog_len;
  int    errors;
  int    cycles;
  int    n_fetch;
  int    n_data;
  logic  done;

  clock_gen clk_src (.clock(clock), .rst(rst));

  core DUT (
    .clock       (clock),
    .rst         (rst),
    .bus_rd_data (bus_rd_data),
    .bus_ack     (bus_ack),
    .bus_wr_data (bus_wr_data),
    .bus_addr    (bus_addr),
    .bus_cyc     (bus_cyc),
    .bus_stb     (bus_stb),
    .bus_we      (bus_we),
    .bus_sel     (bus_sel)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Instruction encoders
  function automatic word_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
                                  input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OP_REG};
  endfunction

  function automatic word_t enc_i(input int imm, input int rs1, input int f3, input int rd,
                                  input opcode_t op);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_s(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], OP_STORE};
  endfunction

  function automatic word_t enc_b(input int f3, input int rs1, input int rs2, input int imm);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], OP_BRANCH};
  endfunction

  function automatic word_t enc_u(input int imm20, input int rd, input opcode_t op);
    return {imm20[19:0], rd[4:0], op};
  endfunction

  function automatic word_t enc_j(input int rd, input int imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], OP_JAL};
  endfunction

  task automatic put(input word_t w);
    mem[prog_len] = w;
    prog_len++;
  endtask

  // Taken branch skips its counter increment, the untaken one does not
  task automatic branch_pair(input int f3, input int t1, input int t2, input int n1,
                             input int n2);
    put(enc_b(f3, t1, t2, 8));
    put(enc_i(1, 20, 0, 20, OP_IMM));
    put(enc_b(f3, n1, n2, 8));
    put(enc_i(1, 20, 0, 20, OP_IMM));
  endtask

  task automatic build_program();
    put(enc_i(512, 0, 0, 1, OP_IMM));
    put(enc_i(0, 1, 2, 2, OP_LOAD));
    put(enc_i(4, 1, 2, 3, OP_LOAD));
    put(enc_i(8, 1, 2, 0, OP_LOAD));
    put(enc_r(0, 3, 2, 0, 4));
    put(enc_r(32, 3, 2, 0, 5));
    put(enc_r(0, 3, 2, 2, 6));
    put(enc_r(0, 3, 2, 3, 7));
    put(enc_r(0, 3, 2, 1, 8));
    put(enc_r(0, 3, 2, 5, 9));
    put(enc_r(32, 3, 2, 5, 10));
    put(enc_r(0, 3, 2, 4, 11));
    put(enc_r(0, 3, 2, 6, 12));
    put(enc_r(0, 3, 2, 7, 13));
    put(enc_s(0, 1, 300));
    for (int r = 4; r <= 13; r++) put(enc_s(r, 1, 256 + 4 * r));
    put(enc_i(-1, 2, 4, 4, OP_IMM));
    put(enc_i(12'h0f0, 3, 6, 5, OP_IMM));
    put(enc_i(12'h7ff, 2, 7, 6, OP_IMM));
    put(enc_i(-5, 2, 2, 7, OP_IMM));
    put(enc_i(-1, 2, 3, 8, OP_IMM));
    put(enc_i(7, 2, 1, 9, OP_IMM));
    put(enc_i(9, 2, 5, 10, OP_IMM));
    put(enc_i(12'h400 | 13, 3, 5, 11, OP_IMM));
    put(enc_i(-100, 3, 0, 12, OP_IMM));
    put(enc_u(20'habcde, 13, OP_LUI));
    put(enc_u(20'h12345, 14, OP_AUIPC));
    for (int r = 4; r <= 14; r++) put(enc_s(r, 1, 320 + 4 * r));
    put(enc_i(-3, 0, 0, 15, OP_IMM));
    put(enc_i(5, 0, 0, 16, OP_IMM));
    branch_pair(0, 15, 15, 15, 16);
    branch_pair(1, 15, 16, 15, 15);
    branch_pair(4, 15, 16, 16, 15);
    branch_pair(5, 16, 15, 15, 16);
    branch_pair(6, 16, 15, 15, 16);
    branch_pair(7, 15, 16, 16, 15);
    put(enc_j(21, 8));
    put(enc_i(100, 20, 0, 20, OP_IMM));
    put(enc_u(0, 22, OP_AUIPC));
    put(enc_i(12, 22, 0, 23, OP_JALR));
    put(enc_i(100, 20, 0, 20, OP_IMM));
    put(enc_s(20, 1, 400));
    put(enc_s(21, 1, 404));
    put(enc_s(23, 1, 408));
    put(enc_s(22, 1, 412));
    put(enc_j(0, 0));
  endtask

  function automatic void ref_write(input logic [4:0] rd, input word_t v);
    if (rd != 5'd0) ref_regs[rd] = v;
  endfunction

  // Steps the reference by one RV32I instruction; kind 0 none, 1 load, 2 store
  function automatic word_t ref_step(input word_t pc, output logic [1:0] kind,
                                     output word_t addr, output word_t data);
    word_t ins, a, b, imm_i, imm_s, imm_b, imm_j, r, next;
    logic  cond;
    ins   = ref_mem[pc[9:2]];
    a     = ref_regs[ins[19:15]];
    b     = ref_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
    next  = pc + 32'd4;
    kind  = 2'd0;
    addr  = '0;
    data  = '0;
    case (ins[6:0])
      OP_LUI:   ref_write(ins[11:7], {ins[31:12], 12'b0});
      OP_AUIPC: ref_write(ins[11:7], pc + {ins[31:12], 12'b0});
      OP_JAL: begin
        ref_write(ins[11:7], pc + 32'd4);
        next = pc + imm_j;
      end
      OP_JALR: begin
        next = (a + imm_i) & ~32'd1;
        ref_write(ins[11:7], pc + 32'd4);
      end
      OP_BRANCH: begin
        case (ins[14:12])
          3'b000:  cond = (a == b);
          3'b001:  cond = (a != b);
          3'b100:  cond = ($signed(a) < $signed(b));
          3'b101:  cond = ($signed(a) >= $signed(b));
          3'b110:  cond = (a < b);
          default: cond = (a >= b);
        endcase
        if (cond) next = pc + imm_b;
      end
      OP_LOAD: begin
        kind = 2'd1;
        addr = a + imm_i;
        ref_write(ins[11:7], ref_mem[addr[9:2]]);
      end
      OP_STORE: begin
        kind = 2'd2;
        addr = a + imm_s;
        data = b;
        ref_mem[addr[9:2]] = b;
      end
      OP_IMM, OP_REG: begin
        if (ins[6:0] == OP_IMM) b = imm_i;
        case (ins[14:12])
          3'b000:  r = (ins[6:0] == OP_REG && ins[30]) ? a - b : a + b;
          3'b001:  r = a << b[4:0];
          3'b010:  r = {31'b0, $signed(a) < $signed(b)};
          3'b011:  r = {31'b0, a < b};
          3'b100:  r = a ^ b;
          3'b101:  r = ins[30] ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
          3'b110:  r = a | b;
          default: r = a & b;
        endcase
        ref_write(ins[11:7], r);
      end
      default: ;
    endcase
    return next;
  endfunction

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
    errors++;
  endtask

  task automatic finish_run();
    $display("Summary: %0d fetches, %0d data transfers, %0d errors", n_fetch, n_data, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  initial begin
    bus_ack     = 1'b0;
    bus_rd_data = '0;
    errors      = 0;
    cycles      = 0;
    n_fetch     = 0;
    n_data      = 0;
    done        = 1'b0;
    prog_len    = 0;
    // First fetch after reset is at address 0
    ref_pc      = 32'h0000_0000;
    for (int i = 0; i < 256; i++) mem[i] = '0;
    for (int i = 0; i < 32; i++) ref_regs[i] = '0;
    build_program();
    // Data region in the upper half
    for (int i = 128; i < 256; i++) begin
      rng_state = xorshift(rng_state);
      mem[i]    = rng_state;
    end
    for (int i = 0; i < 256; i++) ref_mem[i] = mem[i];
  end

  // Bus memory with 0 to 3 cycles of random wait before ack
  logic        armed;
  int          wait_cnt;
  word_t       held_addr;
  word_t       held_data;
  logic        held_we;

  always @(posedge clock) begin
    if (rst) begin
      bus_ack <= 1'b0;
      armed   = 1'b0;
    end else if (bus_cyc && bus_ack) begin
      bus_ack <= 1'b0;
      armed   = 1'b0;
      if (bus_we) mem[bus_addr[9:2]] = bus_wr_data;
    end else if (bus_cyc) begin
      if (!armed) begin
        armed     = 1'b1;
        held_addr = bus_addr;
        held_data = bus_wr_data;
        held_we   = bus_we;
        rng_state = xorshift(rng_state);
        wait_cnt  = int'(rng_state[1:0]);
      end else begin
        assert (bus_addr == held_addr) else report_mismatch("stall address", held_addr, bus_addr);
        assert (bus_we == held_we) else report_mismatch("stall we", 32'(held_we), 32'(bus_we));
        if (held_we) begin
          assert (bus_wr_data == held_data)
            else report_mismatch("stall write data", held_data, bus_wr_data);
        end
      end
      if (wait_cnt == 0) begin
        bus_ack     <= 1'b1;
        bus_rd_data <= mem[bus_addr[9:2]];
      end else begin
        wait_cnt--;
      end
    end
  end

  // Compares every completed transfer with the reference
  logic [1:0] exp_kind;
  word_t      exp_addr;
  word_t      exp_data;
  word_t      last_fetch;
  logic       have_last = 1'b0;
  logic       pending = 1'b0;

  always @(posedge clock) begin
    assert (bus_stb == bus_cyc) else report_mismatch("bus stb", 32'(bus_cyc), 32'(bus_stb));
    if (rst) begin
      assert (!bus_cyc) else begin
        $display("Bus cycle opened while reset was asserted");
        errors++;
      end
    end else if (!done && bus_cyc && bus_ack) begin
      assert (bus_sel == 4'b1111) else report_mismatch("byte select", 32'hf, 32'(bus_sel));
      if (pending) begin
        pending = 1'b0;
        n_data++;
        assert (bus_addr == exp_addr) else report_mismatch("data address", exp_addr, bus_addr);
        assert (bus_we == (exp_kind == 2'd2))
          else report_mismatch("data we", 32'(exp_kind == 2'd2), 32'(bus_we));
        if (exp_kind == 2'd2) begin
          assert (bus_wr_data == exp_data)
            else report_mismatch("store data", exp_data, bus_wr_data);
        end
      end else begin
        n_fetch++;
        assert (!bus_we) else report_mismatch("fetch we", 32'd0, 32'(bus_we));
        assert (bus_addr == ref_pc) else report_mismatch("fetch address", ref_pc, bus_addr);
        if (have_last && bus_addr == last_fetch) begin
          done = 1'b1;
        end else begin
          last_fetch = bus_addr;
          have_last  = 1'b1;
          ref_pc     = ref_step(ref_pc, exp_kind, exp_addr, exp_data);
          pending    = (exp_kind != 2'd0);
        end
      end
    end
  end

  always @(posedge clock) begin
    cycles++;
    if (done) begin
      finish_run();
    end else if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the program did not reach its final loop within %0d cycles",
               MAX_CYCLES);
      errors++;
      finish_run();
    end
  end

endmodule

`default_nettype wire
